//--- Bender.yml
package:
  name: snd_dac

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/snd_pkg.sv
      - src/snd_pcm_cond.sv
      - src/snd_sd_dac.sv
      - src/snd_dac_top.sv
  - target: simulation
    files:
      - sim/snd_dac_props.sv
      - sim/snd_dac_tb.sv

//--- flist.f
+incdir+include
src/snd_pkg.sv
src/snd_pcm_cond.sv
src/snd_sd_dac.sv
src/snd_dac_top.sv
sim/snd_dac_props.sv
sim/snd_dac_tb.sv

//--- include/snd_settings.svh
// Build settings for the audio DAC stage, pulled in by the package that carries its types

`ifndef SND_SETTINGS_SVH
`define SND_SETTINGS_SVH

// Width of one PCM sample from the game sound core
`define SND_PCM_W 16

// clk_dac cycles between two modulator steps
// Also sets the length of the enable ring
`define SND_CEN_DIV 4

// 1 when the sound core delivers two's complement samples
// 0 when samples already come as offset binary
`define SND_SIGNED 1

// 1 gives the right channel its own chain
// 0 builds a mono stage where the right output copies the left
`define SND_STEREO 1

`endif

//--- sim/snd_dac_props.sv
// Concurrent checks on the DAC top level, attached to every snd_dac_top instance by bind
`default_nettype none
`timescale 1ns/100ps

module snd_dac_props
    import snd_pkg::*;
(
    input logic clk_dac,
    input logic rst,
    input logic cen_i,
    input logic pwm_left_i,
    input logic pwm_right_i
);

    // Failed assertion attempts, read back by the testbench
    int unsigned fail_cnt = 0;

    // Both streams quiet under reset
    reset_low_a : assert property (@(posedge clk_dac)
        rst |-> (!pwm_left_i && !pwm_right_i))
        else begin
            fail_cnt <= fail_cnt + 1;
            $error("DAC output high during reset");
        end

    // One enable, then CEN_DIV-1 idle cycles, then the next one
    cen_spacing_a : assert property (@(posedge clk_dac) disable iff (rst)
        cen_i |=> !cen_i [*CEN_DIV-1] ##1 cen_i)
        else begin
            fail_cnt <= fail_cnt + 1;
            $error("enable spacing broken");
        end

    cen_no_gap_a : assert property (@(posedge clk_dac) disable iff (rst)
        !cen_i [*CEN_DIV-1] |=> cen_i)
        else begin
            fail_cnt <= fail_cnt + 1;
            $error("enable missing after idle cycles");
        end

    // Streams only move right after an enable
    left_hold_a : assert property (@(posedge clk_dac) disable iff (rst)
        (pwm_left_i != $past(pwm_left_i)) |-> $past(cen_i))
        else begin
            fail_cnt <= fail_cnt + 1;
            $error("left output changed without an enable");
        end

    right_hold_a : assert property (@(posedge clk_dac) disable iff (rst)
        (pwm_right_i != $past(pwm_right_i)) |-> $past(cen_i))
        else begin
            fail_cnt <= fail_cnt + 1;
            $error("right output changed without an enable");
        end

    mono_mirror_a : assert property (@(posedge clk_dac)
        STEREO || (pwm_right_i == pwm_left_i))
        else begin
            fail_cnt <= fail_cnt + 1;
            $error("mono right output differs from left");
        end

endmodule : snd_dac_props

bind snd_dac_top snd_dac_props u_props (
    .clk_dac     ( clk_dac     ),
    .rst         ( rst         ),
    .cen_i       ( cen         ),
    .pwm_left_i  ( pwm_left_o  ),
    .pwm_right_i ( pwm_right_o )
);

`default_nettype wire

//--- sim/snd_dac_tb.sv
// Self-checking testbench for the audio DAC stage, replays the pulse count trace on the top level
`default_nettype none
`timescale 1ns/100ps

module snd_dac_tb
    import snd_pkg::*;
();

    localparam TRACE_FILE = "sim/snd_trace.txt";
    localparam int unsigned RESET_CYCLES = 8;
    // Enables per trace row
    localparam int unsigned WINDOW = 64;
    localparam int unsigned ROW_CYCLES = WINDOW * CEN_DIV;
    localparam int unsigned MARGIN_CYCLES = 100;
    localparam int unsigned NAME_LEN = 24;

    logic clk_dac = 1'b0;
    logic rst;
    pcm_t snd_left_i;
    pcm_t snd_right_i;
    logic pwm_left_o;
    logic pwm_right_o;

    // Trace rows
    string       name_q[$];
    pcm_t        left_q[$];
    pcm_t        right_q[$];
    int unsigned exp_left_q[$];
    int unsigned exp_right_q[$];
    dac_word_t   word_q[$];
    int unsigned row_cnt = 0;
    bit          trace_loaded = 1'b0;

    snd_dac_top i_dut (
        .clk_dac     ( clk_dac     ),
        .rst         ( rst         ),
        .snd_left_i  ( snd_left_i  ),
        .snd_right_i ( snd_right_i ),
        .pwm_left_o  ( pwm_left_o  ),
        .pwm_right_o ( pwm_right_o )
    );

    always begin
        #2 clk_dac = ~clk_dac;
    end

    // Offset binary by adding half the range, then scale by eight under a zero top bit
    function automatic dac_word_t expected_word(input pcm_t sample);
        pcm_t offset;
        offset = SIGN_FLIP ? pcm_t'(sample + (1 << (PCM_W - 1))) : sample;
        return dac_word_t'(offset) << 3;
    endfunction

    task automatic check_count(input string test_name, input int unsigned exp_cnt,
                               input int unsigned act_cnt);
        if (act_cnt != exp_cnt) begin
            $display("Fail %0s: expected %0d pulses, actual %0d", test_name, exp_cnt, act_cnt);
            $display("Simulation failed");
            $fatal(1, "pulse count mismatch");
        end
    endtask

    task automatic check_pcm_word(input string test_name, input dac_word_t exp_word,
                                  input dac_word_t act_word);
        if (act_word !== exp_word) begin
            $display("Fail %0s: expected %h, actual %h", test_name, exp_word, act_word);
            $display("Simulation failed");
            $fatal(1, "DAC word mismatch");
        end
    endtask

    task automatic check_level(input string test_name, input logic exp_bit,
                               input logic act_bit);
        if (act_bit !== exp_bit) begin
            $display("Fail %0s: expected %b, actual %b", test_name, exp_bit, act_bit);
            $display("Simulation failed");
            $fatal(1, "output level mismatch");
        end
    endtask

    // Lines starting with a hash are comments
    task automatic load_trace();
        int                    fd;
        int                    n;
        string                 line;
        logic [8*NAME_LEN-1:0] name_v;
        pcm_t                  left_v;
        pcm_t                  right_v;
        int unsigned           el_v;
        int unsigned           er_v;
        dac_word_t             word_v;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Error: cannot open the trace file %0s", TRACE_FILE);
            $display("Simulation failed");
            $fatal(1, "missing trace");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %h %h %d %d %h", name_v, left_v, right_v,
                            el_v, er_v, word_v);
                if (n == 6) begin
                    name_q.push_back(string'(name_v));
                    left_q.push_back(left_v);
                    right_q.push_back(right_v);
                    exp_left_q.push_back(el_v);
                    exp_right_q.push_back(er_v);
                    word_q.push_back(word_v);
                end else if (n > 0) begin
                    $display("Error: trace line has the wrong number of columns: %0s", line);
                    $display("Simulation failed");
                    $fatal(1, "malformed trace");
                end
            end
        end
        $fclose(fd);
        row_cnt = name_q.size();
        if (row_cnt == 0) begin
            $display("Error: the trace file holds no rows");
            $display("Simulation failed");
            $fatal(1, "empty trace");
        end
    endtask

    initial begin : run_trace
        int unsigned j;
        int unsigned last_j;
        int unsigned r;
        int unsigned pos;
        int unsigned cnt_left;
        int unsigned cnt_right;
        int unsigned exp_right;
        rst = 1'b1;
        snd_left_i = '0;
        snd_right_i = '0;
        cnt_left = 0;
        cnt_right = 0;
        load_trace();
        trace_loaded = 1'b1;

        repeat (RESET_CYCLES - 1) begin
            @(negedge clk_dac);
            check_level("reset_left", 1'b0, pwm_left_o);
            check_level("reset_right", 1'b0, pwm_right_o);
        end
        @(posedge clk_dac);
        rst <= 1'b0;

        // First enable lands on the third edge after release
        repeat (2) @(posedge clk_dac);

        // One pass per enable, starting one cycle ahead of it
        last_j = row_cnt * WINDOW + 1;
        for (j = 0; j <= last_j; j++) begin
            if ((j % WINDOW) == 0 && (j / WINDOW) < row_cnt) begin
                snd_left_i  <= left_q[j / WINDOW];
                snd_right_i <= right_q[j / WINDOW];
            end
            @(negedge clk_dac);
            if (j < 2) begin
                check_level("idle_left", 1'b0, pwm_left_o);
                check_level("idle_right", 1'b0, pwm_right_o);
            end
            // Word was captured on the enable just before
            if ((j % WINDOW) == 1 && (j / WINDOW) < row_cnt) begin
                r = j / WINDOW;
                check_pcm_word({name_q[r], "/trace_word"}, word_q[r], expected_word(left_q[r]));
                check_pcm_word({name_q[r], "/dut_word"}, expected_word(left_q[r]),
                               i_dut.word_left);
            end
            // Output bit of the step two enables after the sample went out
            if (j >= 2) begin
                r = (j - 2) / WINDOW;
                pos = (j - 2) % WINDOW;
                if (pwm_left_o === 1'b1) begin
                    cnt_left++;
                end
                if (pwm_right_o === 1'b1) begin
                    cnt_right++;
                end
                if (pos == WINDOW - 1) begin
                    exp_right = STEREO ? exp_right_q[r] : exp_left_q[r];
                    check_count({name_q[r], "/left"}, exp_left_q[r], cnt_left);
                    check_count({name_q[r], "/right"}, exp_right, cnt_right);
                    cnt_left = 0;
                    cnt_right = 0;
                end
            end
            repeat (CEN_DIV) @(posedge clk_dac);
        end

        if (i_dut.u_props.fail_cnt == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Error: %0d property checks failed during the run", i_dut.u_props.fail_cnt);
            $display("Simulation failed");
            $fatal(1, "property failures");
        end
    end

    initial begin : prop_watch
        wait (i_dut.u_props.fail_cnt != 0);
        $display("Error: a property check on the DUT failed");
        $display("Simulation failed");
        $fatal(1, "property failure");
    end

    initial begin : watchdog
        int unsigned limit;
        wait (trace_loaded);
        limit = RESET_CYCLES + row_cnt * ROW_CYCLES + MARGIN_CYCLES;
        repeat (limit) @(posedge clk_dac);
        $display("Error: the trace did not finish within %0d clk_dac cycles", limit);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

endmodule : snd_dac_tb

`default_nettype wire

//--- sim/snd_trace.txt
# name left_sample right_sample left_count right_count left_word
# samples and words in hex, counts in decimal over 64 enables, rows run back to back from reset
mid_zero    0000 0000 16 16 40000
sign_max    7fff 7fff 31 31 7fff8
sign_min    8000 8000  0  0 00000
split_lr    4000 c000 24  8 60000
split_rl    f000 1000 14 18 38000
step_a      0123 fedc 17 16 40918
step_b      1555 eaab 18 14 4aaa8
step_c      2aaa d556 22 10 55550
step_d      f00f 0ff0 14 18 38078
step_e      8001 7ffe  0 32 00008
step_f      0001 ffff 16 16 40008
mid_again   0000 0000 16 16 40000
quarter     c000 4000  8 24 20000
ramp_1      0400 fc00 16 16 42000
ramp_2      0800 f800 17 15 44000
ramp_3      0c00 f400 18 14 46000
odd_mix     3579 c687 22  9 5abc8

//--- src/snd_dac_top.sv
// Audio output stage top level with the DAC enable ring and the left and right channel chains
`default_nettype none
`timescale 1ns/100ps

module snd_dac_top
    import snd_pkg::*;
(
    input  logic clk_dac,
    input  logic rst,
    // Sample levels from the game sound core
    input  pcm_t snd_left_i,
    input  pcm_t snd_right_i,
    // One-bit streams, filtered off chip
    output logic pwm_left_o,
    output logic pwm_right_o
);

    // Ring starts with a single one at bit 2
    // With four bits the first enable shows up two shifts after reset
    localparam logic [CEN_DIV-1:0] RING_INIT = CEN_DIV'(4);

    // Rotating one-hot enable ring
    logic [CEN_DIV-1:0] cen_ring;
    // Modulator step enable shared by both channels
    logic               cen;

    // Left channel word between conditioning and modulator
    dac_word_t          word_left;

    // Rotate right every clk_dac cycle
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            cen_ring <= RING_INIT;
        end else begin
            cen_ring <= {cen_ring[0], cen_ring[CEN_DIV-1:1]};
        end
    end

    assign cen = cen_ring[0];

    // Left chain is always present
    snd_pcm_cond u_cond_left (
        .clk_dac ( clk_dac    ),
        .rst     ( rst        ),
        .cen_i   ( cen        ),
        .pcm_i   ( snd_left_i ),
        .word_o  ( word_left  )
    );

    snd_sd_dac u_dac_left (
        .clk_dac ( clk_dac    ),
        .rst     ( rst        ),
        .cen_i   ( cen        ),
        .word_i  ( word_left  ),
        .dac_o   ( pwm_left_o )
    );

    generate
        if (STEREO) begin : g_stereo
            // Right channel word, private to the right chain
            dac_word_t word_right;

            snd_pcm_cond u_cond_right (
                .clk_dac ( clk_dac     ),
                .rst     ( rst         ),
                .cen_i   ( cen         ),
                .pcm_i   ( snd_right_i ),
                .word_o  ( word_right  )
            );

            snd_sd_dac u_dac_right (
                .clk_dac ( clk_dac     ),
                .rst     ( rst         ),
                .cen_i   ( cen         ),
                .word_i  ( word_right  ),
                .dac_o   ( pwm_right_o )
            );
        end else begin : g_mono
            // Mono build, the right input has no chain
            assign pwm_right_o = pwm_left_o;
        end
    endgenerate

endmodule : snd_dac_top

`default_nettype wire

//--- src/snd_pcm_cond.sv
// Per-channel sample conditioning that registers a padded DAC word on every modulator enable
`default_nettype none
`timescale 1ns/100ps

module snd_pcm_cond
    import snd_pkg::*;
(
    input  logic      clk_dac,
    input  logic      rst,
    // Modulator step enable from the top level ring
    input  logic      cen_i,
    // Raw sample level from the sound core
    input  pcm_t      pcm_i,
    // Padded word held steady between enables
    output dac_word_t word_o
);

    // Offset binary version of the incoming sample
    pcm_t      pcm_ob;
    // Word built from the current sample, before the register
    dac_word_t word_next;

    // Turn a two's complement sample into offset binary
    // Only the sign bit moves, so midscale lands on 8000h
    function automatic pcm_t to_offset_bin(input pcm_t pcm);
        pcm_t res;
        res = pcm;
        res[PCM_W-1] = pcm[PCM_W-1] ^ SIGN_FLIP;
        return res;
    endfunction

    // Place the sample inside the wider modulator word
    // The zero on top keeps the ones density under one half
    // The low zeros scale the sample up to the accumulator range
    function automatic dac_word_t pad_word(input pcm_t pcm);
        dac_word_t res;
        res = {1'b0, pcm, 3'b000};
        return res;
    endfunction

    always_comb begin
        pcm_ob    = to_offset_bin(pcm_i);
        word_next = pad_word(pcm_ob);
    end

    // Sample capture
    // Anything the core changes between enables is ignored
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            word_o <= '0;
        end else if (cen_i) begin
            word_o <= word_next;
        end
    end

endmodule : snd_pcm_cond

`default_nettype wire

//--- src/snd_pkg.sv
// Shared sample and DAC word types for the audio output stage, imported by the RTL and testbench
`default_nettype none

package snd_pkg;

`include "snd_settings.svh"

    // Widths taken from the build settings
    localparam int unsigned PCM_W = `SND_PCM_W;
    localparam int unsigned DAC_W = `SND_PCM_W + 4;

    // Modulator step spacing in clk_dac cycles
    localparam int unsigned CEN_DIV = `SND_CEN_DIV;

    // Top bit inversion for two's complement input
    localparam bit SIGN_FLIP = `SND_SIGNED;

    // Second channel chain present
    localparam bit STEREO = `SND_STEREO;

    // One channel sample as delivered by the sound core
    typedef logic [PCM_W-1:0] pcm_t;

    // Modulator input word
    // Leading zero, conditioned sample, three zero bits
    typedef logic [DAC_W-1:0] dac_word_t;

endpackage : snd_pkg

`default_nettype wire

//--- src/snd_sd_dac.sv
// First-order one-bit sigma-delta modulator that turns a DAC word into a pulse stream
`default_nettype none
`timescale 1ns/100ps

module snd_sd_dac
    import snd_pkg::*;
(
    input  logic      clk_dac,
    input  logic      rst,
    // One modulator step per enable
    input  logic      cen_i,
    // Conditioned word, stable between enables
    input  dac_word_t word_i,
    // One-bit stream for the off-chip RC filter
    output logic      dac_o
);

    // Error accumulator, same width as the word
    dac_word_t        acc;

    // Accumulator plus word with room for the carry
    logic [DAC_W:0]   acc_sum;
    // Carry out of the add becomes the next output bit
    logic             carry;
    // Low part kept as the residual error
    dac_word_t        acc_next;

    // Zero extend both operands by one bit and add
    // The carry rate equals word_i over 2**DAC_W
    always_comb begin
        acc_sum  = {1'b0, acc} + {1'b0, word_i};
        carry    = acc_sum[DAC_W];
        acc_next = acc_sum[DAC_W-1:0];
    end

    // Accumulator update
    // Holds its value on cycles without an enable
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else if (cen_i) begin
            acc <= acc_next;
        end
    end

    // Output bit register
    // Each bit stays on the pin for one full enable period
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            dac_o <= 1'b0;
        end else if (cen_i) begin
            dac_o <= carry;
        end
    end

endmodule : snd_sd_dac

`default_nettype wire
